// File: Bender.yml
package:
  name: rdm_input_stage

export_include_dirs:
  - include

sources:
  - files:
      - hdl/rdm_pkg.sv
      - hdl/rdm_buf_wr_if.sv
      - hdl/rdm_slot_setup.sv
      - hdl/rdm_user_ctx.sv
      - hdl/rdm_addr_ctrl.sv
      - hdl/rdm_llr_packer.sv
      - hdl/rdm_input_buffer.sv
      - hdl/rdm_input_stage.sv
  - target: test
    files:
      - testbench/tb_rdm_input_stage.sv

// File: hdl/rdm_addr_ctrl.sv
/*
 * Demux handshake, per-user contexts, write address selection
 * and the pending code-block record
 */
`timescale 1ns/1ps
`include "rdm_settings.svh"

module rdm_addr_ctrl
(
	input  logic                   i_core_clk,
	input  logic                   i_rx_rstn,
	input  logic                   i_slot_start,
	input  logic                   i_setup_busy,
	input  rdm_pkg::user_cfg_arr_t i_cfg,
	input  rdm_pkg::base_arr_t     i_base,
	input  logic                   i_demux_valid,
	input  rdm_pkg::user_idx_t     i_demux_user_idx,
	input  logic                   i_cb_ready,
	output logic                   o_demux_ready,
	output logic                   o_two_layer,
	output rdm_pkg::qm_t           o_qm,
	output rdm_pkg::bank_sel_t     o_low_bits,
	output logic                   o_cb_valid,
	output rdm_pkg::cb_rec_t       o_cb_rec,
	rdm_buf_wr_if.addr_side        wr
);
	import rdm_pkg::*;

	logic [`RDM_NUM_USERS-1:0]         user_acc;
	logic [`RDM_NUM_USERS-1:0]         user_half;
	logic [`RDM_NUM_USERS-1:0]         user_cb_end;
	re_cnt_t [`RDM_NUM_USERS-1:0]      user_offs;
	re_cnt_t [`RDM_NUM_USERS-1:0]      user_size;
	logic [$clog2(`RDM_NUM_USERS)-1:0] sel;
	logic                              idx_ok;
	logic                              cb_done;
	re_cnt_t                           word_addr;

	//////////////////////////////////////////////////
	// Handshake and user selection

	assign o_demux_ready = !i_setup_busy && !o_cb_valid;
	assign idx_ok = (i_demux_user_idx < `RDM_NUM_USERS);
	assign sel = i_demux_user_idx[$clog2(`RDM_NUM_USERS)-1:0];

	assign wr.wr_en = i_demux_valid && o_demux_ready && idx_ok;    // Unknown users are dropped
	assign cb_done = wr.wr_en && user_cb_end[sel];

	for (genvar u = 0; u < `RDM_NUM_USERS; u++)
	begin : g_user
		assign user_acc[u] = wr.wr_en && (sel == u);

		rdm_user_ctx u_ctx
		(
			.i_core_clk   (i_core_clk),
			.i_rx_rstn    (i_rx_rstn),
			.i_slot_start (i_slot_start),
			.i_accept     (user_acc[u]),
			.i_cfg        (i_cfg[u]),
			.o_word_addr  (user_offs[u]),
			.o_half       (user_half[u]),
			.o_cb_end     (user_cb_end[u]),
			.o_cb_size    (user_size[u])
		);
	end

	//////////////////////////////////////////////////
	// Write address

	assign word_addr = i_base[sel] + user_offs[sel];
	assign wr.wr_addr = {user_half[sel], word_addr[`RDM_CNT_W-1:$bits(bank_sel_t)]};
	assign o_low_bits = word_addr[$bits(bank_sel_t)-1:0];
	assign o_two_layer = i_cfg[sel].two_layer;
	assign o_qm = i_cfg[sel].qm;

	//////////////////////////////////////////////////
	// Code-block record, held until taken

	always_ff @(posedge i_core_clk or negedge i_rx_rstn)
	begin
		if (!i_rx_rstn)
			o_cb_valid <= 1'b0;
		else if (cb_done)
			o_cb_valid <= 1'b1;
		else if (i_cb_ready)
			o_cb_valid <= 1'b0;
	end

	always_ff @(posedge i_core_clk)
	begin
		if (cb_done)
		begin
			o_cb_rec.user <= i_demux_user_idx;
			o_cb_rec.half <= user_half[sel];    // Half the block was written to
			o_cb_rec.size <= user_size[sel];
		end
	end

	assert property (@(posedge i_core_clk) disable iff (!i_rx_rstn)
		o_cb_valid |-> !wr.wr_en);

	assert property (@(posedge i_core_clk) disable iff (!i_rx_rstn)
		o_cb_valid && !i_cb_ready |=> o_cb_valid && $stable(o_cb_rec));

endmodule

// File: hdl/rdm_buf_wr_if.sv
/*
 * Input buffer write bus with address, data and memory modports
 */
`timescale 1ns/1ps

interface rdm_buf_wr_if;
	import rdm_pkg::*;

	logic       wr_en;
	buf_addr_t  wr_addr;    // {half, row}
	bank_we_t   bank_we;
	bank_data_t wr_data;

	modport addr_side (output wr_en, output wr_addr);
	modport data_side (output bank_we, output wr_data);
	modport mem_side (input wr_en, input wr_addr, input bank_we, input wr_data);

endinterface

// File: hdl/rdm_input_buffer.sv
/*
 * Sixteen banks of the input buffer, per-bank write enable,
 * common write row and a registered common read port
 */
`timescale 1ns/1ps
`include "rdm_settings.svh"

module rdm_input_buffer
(
	input  logic                i_core_clk,
	input  rdm_pkg::buf_addr_t  i_rd_addr,
	output rdm_pkg::bank_data_t o_rd_data,
	rdm_buf_wr_if.mem_side      wr
);
	import rdm_pkg::*;

	for (genvar b = 0; b < `RDM_NUM_BANKS; b++)
	begin : g_bank
		bank_word_t mem [0:(1 << `RDM_BUF_AW)-1];
		bank_word_t rd_q;

		always_ff @(posedge i_core_clk)
		begin
			if (wr.wr_en && wr.bank_we[b])
				mem[wr.wr_addr] <= wr.wr_data[b];
			rd_q <= mem[i_rd_addr];    // Old data on a same-cycle write
		end

		assign o_rd_data[b] = rd_q;
	end

endmodule

// File: hdl/rdm_input_stage.sv
/*
 * Input stage top level: slot setup, address control,
 * LLR packing and the banked input buffer
 */
`timescale 1ns/1ps
`include "rdm_settings.svh"

module rdm_input_stage
(
	input  logic                                  i_core_clk,
	input  logic                                  i_rx_rstn,
	input  logic                                  i_rdm_slot_start,
	input  logic [`RDM_NUM_USERS*`RDM_SZ_W-1:0]   i_users_e0_sz,
	input  logic [`RDM_NUM_USERS*`RDM_SZ_W-1:0]   i_users_e1_sz,
	input  logic [`RDM_NUM_USERS*`RDM_CB_W-1:0]   i_users_e0_num,
	input  logic [`RDM_NUM_USERS-1:0]             i_layer_indicator,
	input  logic [`RDM_NUM_USERS*`RDM_QM_W-1:0]   i_users_qm,
	input  logic                                  i_demux_valid,
	input  logic [3:0]                            i_demux_user_idx,
	input  logic [`RDM_DEMUX_W-1:0]               i_demux_rx,
	input  logic                                  i_cb_ready,
	input  logic [`RDM_BUF_AW-1:0]                i_rd_addr,
	output logic                                  o_demux_ready,
	output logic                                  o_cb_valid,
	output logic [3:0]                            o_cb_user,
	output logic                                  o_cb_half,
	output logic [`RDM_CNT_W-1:0]                 o_cb_size,
	output logic [`RDM_NUM_BANKS*`RDM_BANK_W-1:0] o_rd_data
);
	import rdm_pkg::*;

	user_cfg_arr_t cfg;
	base_arr_t     base;
	logic          setup_busy;
	logic          two_layer;
	qm_t           qm;
	bank_sel_t     low_bits;
	cb_rec_t       cb_rec;

	rdm_buf_wr_if wr_bus ();

	// Per-user fields out of the flat input vectors
	for (genvar u = 0; u < `RDM_NUM_USERS; u++)
	begin : g_cfg
		assign cfg[u].e0_sz = i_users_e0_sz[u*`RDM_SZ_W +: `RDM_SZ_W];
		assign cfg[u].e1_sz = i_users_e1_sz[u*`RDM_SZ_W +: `RDM_SZ_W];
		assign cfg[u].e0_num = i_users_e0_num[u*`RDM_CB_W +: `RDM_CB_W];
		assign cfg[u].two_layer = i_layer_indicator[u];
		assign cfg[u].qm = i_users_qm[u*`RDM_QM_W +: `RDM_QM_W];
	end

	assign o_cb_user = cb_rec.user;
	assign o_cb_half = cb_rec.half;
	assign o_cb_size = cb_rec.size;

	rdm_slot_setup u_setup
	(
		.i_core_clk       (i_core_clk),
		.i_rx_rstn        (i_rx_rstn),
		.i_rdm_slot_start (i_rdm_slot_start),
		.i_cfg            (cfg),
		.o_base           (base),
		.o_setup_busy     (setup_busy)
	);

	rdm_addr_ctrl u_addr
	(
		.i_core_clk       (i_core_clk),
		.i_rx_rstn        (i_rx_rstn),
		.i_slot_start     (i_rdm_slot_start),
		.i_setup_busy     (setup_busy),
		.i_cfg            (cfg),
		.i_base           (base),
		.i_demux_valid    (i_demux_valid),
		.i_demux_user_idx (i_demux_user_idx),
		.i_cb_ready       (i_cb_ready),
		.o_demux_ready    (o_demux_ready),
		.o_two_layer      (two_layer),
		.o_qm             (qm),
		.o_low_bits       (low_bits),
		.o_cb_valid       (o_cb_valid),
		.o_cb_rec         (cb_rec),
		.wr               (wr_bus.addr_side)
	);

	rdm_llr_packer u_pack
	(
		.i_sample    (i_demux_rx),
		.i_two_layer (two_layer),
		.i_qm        (qm),
		.i_low_bits  (low_bits),
		.wr          (wr_bus.data_side)
	);

	rdm_input_buffer u_buf
	(
		.i_core_clk (i_core_clk),
		.i_rd_addr  (i_rd_addr),
		.o_rd_data  (o_rd_data),
		.wr         (wr_bus.mem_side)
	);

endmodule

// File: hdl/rdm_llr_packer.sv
/*
 * Bank word data and bank write enables from the layer mode,
 * Qm and the low word-address bits
 */
`timescale 1ns/1ps
`include "rdm_settings.svh"

module rdm_llr_packer
(
	input  rdm_pkg::demux_word_t i_sample,
	input  logic                 i_two_layer,
	input  rdm_pkg::qm_t         i_qm,
	input  rdm_pkg::bank_sel_t   i_low_bits,
	rdm_buf_wr_if.data_side      wr
);
	import rdm_pkg::*;

	bank_word_t llr_lo;
	bank_word_t llr_hi;

	// Two layers, one group of 6*Qm LLRs per layer
	always_comb
	begin
		case (i_qm)
			4'd1:
			begin
				llr_lo = {42'd0, i_sample[5:0]};
				llr_hi = {42'd0, i_sample[11:6]};
			end
			4'd2:
			begin
				llr_lo = {36'd0, i_sample[11:0]};
				llr_hi = {36'd0, i_sample[23:12]};
			end
			4'd4:
			begin
				llr_lo = {24'd0, i_sample[23:0]};
				llr_hi = {24'd0, i_sample[47:24]};
			end
			4'd6:
			begin
				llr_lo = {12'd0, i_sample[35:0]};
				llr_hi = {12'd0, i_sample[71:36]};
			end
			4'd8:
			begin
				llr_lo = i_sample[47:0];
				llr_hi = i_sample[95:48];
			end
			default:
			begin
				llr_lo = '0;
				llr_hi = '0;
			end
		endcase
	end

	always_comb
	begin
		for (int b = 0; b < `RDM_NUM_BANKS; b++)
		begin
			if (!i_two_layer)
				wr.wr_data[b] = i_sample[`RDM_BANK_W-1:0];
			else if ((b % 2) == 1)
				wr.wr_data[b] = llr_hi;
			else
				wr.wr_data[b] = llr_lo;
		end

		if (!i_two_layer)
			wr.bank_we = bank_we_t'(1) << i_low_bits;
		else
			wr.bank_we = bank_we_t'(3) << {i_low_bits[$bits(bank_sel_t)-1:1], 1'b0};    // Bank pair
	end

endmodule

// File: hdl/rdm_pkg.sv
/*
 * Shared types: indices, counters, bank words, per-user
 * configuration and the code-block record
 */
package rdm_pkg;
`include "rdm_settings.svh"

	typedef logic [3:0]                 user_idx_t;
	typedef logic [`RDM_CNT_W-1:0]      re_cnt_t;
	typedef logic [`RDM_CB_W-1:0]       cb_cnt_t;
	typedef logic [`RDM_QM_W-1:0]       qm_t;
	typedef logic [`RDM_BUF_AW-1:0]     buf_addr_t;
	typedef logic [3:0]                 bank_sel_t;    // Bank number within a row
	typedef logic [`RDM_BANK_W-1:0]     bank_word_t;
	typedef logic [`RDM_NUM_BANKS-1:0]  bank_we_t;
	typedef logic [`RDM_DEMUX_W-1:0]    demux_word_t;

	typedef struct packed {
		logic [`RDM_SZ_W-1:0] e0_sz;    // REs minus one
		logic [`RDM_SZ_W-1:0] e1_sz;
		cb_cnt_t              e0_num;   // Code blocks of E0 size
		logic                 two_layer;
		qm_t                  qm;
	} user_cfg_t;

	typedef user_cfg_t [`RDM_NUM_USERS-1:0]  user_cfg_arr_t;
	typedef re_cnt_t [`RDM_NUM_USERS-1:0]    base_arr_t;
	typedef bank_word_t [`RDM_NUM_BANKS-1:0] bank_data_t;

	typedef struct packed {
		user_idx_t user;
		logic      half;
		re_cnt_t   size;
	} cb_rec_t;

endpackage

// File: hdl/rdm_slot_setup.sv
/*
 * Per-user buffer base addresses, accumulated from the rounded
 * E1 sizes over the setup window after each slot start
 */
`timescale 1ns/1ps
`include "rdm_settings.svh"

module rdm_slot_setup
(
	input  logic                   i_core_clk,
	input  logic                   i_rx_rstn,
	input  logic                   i_rdm_slot_start,
	input  rdm_pkg::user_cfg_arr_t i_cfg,
	output rdm_pkg::base_arr_t     o_base,
	output logic                   o_setup_busy
);
	import rdm_pkg::*;

	logic [3:0]           step_cnt;
	re_cnt_t              acc_sum;
	re_cnt_t              acc_in;
	logic [`RDM_SZ_W-1:0] e1_rnd;

	assign o_setup_busy = (step_cnt < `RDM_SETUP_CYCLES);
	assign acc_in = (step_cnt == '0) ? '0 : acc_sum;    // User 0 starts at zero
	assign e1_rnd = {i_cfg[step_cnt[2:0]].e1_sz[`RDM_SZ_W-1:4] + 1'b1, 4'd0};

	// Setup also runs once after reset
	always_ff @(posedge i_core_clk or negedge i_rx_rstn)
	begin
		if (!i_rx_rstn)
			step_cnt <= '0;
		else if (i_rdm_slot_start)
			step_cnt <= '0;
		else if (o_setup_busy)
			step_cnt <= step_cnt + 4'd1;
	end

	always_ff @(posedge i_core_clk or negedge i_rx_rstn)
	begin
		if (!i_rx_rstn)
		begin
			acc_sum <= '0;
			o_base  <= '0;
		end
		else if (!i_rdm_slot_start && step_cnt < `RDM_NUM_USERS)
		begin
			o_base[step_cnt[2:0]] <= acc_in;
			acc_sum <= acc_in + e1_rnd[`RDM_CNT_W-1:0];
		end
	end

	assert property (@(posedge i_core_clk) disable iff (!i_rx_rstn)
		step_cnt <= `RDM_SETUP_CYCLES);

endmodule

// File: hdl/rdm_user_ctx.sv
/*
 * One user's write context: RE counter, ping-pong half,
 * code-block count and code-block end detection
 */
`timescale 1ns/1ps
`include "rdm_settings.svh"

module rdm_user_ctx
(
	input  logic               i_core_clk,
	input  logic               i_rx_rstn,
	input  logic               i_slot_start,
	input  logic               i_accept,
	input  rdm_pkg::user_cfg_t i_cfg,
	output rdm_pkg::re_cnt_t   o_word_addr,
	output logic               o_half,
	output logic               o_cb_end,
	output rdm_pkg::re_cnt_t   o_cb_size
);
	import rdm_pkg::*;

	re_cnt_t              re_cnt;
	cb_cnt_t              cb_cnt;
	logic [`RDM_SZ_W-1:0] limit;
	re_cnt_t              step;

	// E0 limit until the E0 blocks are done
	assign limit = (cb_cnt < i_cfg.e0_num) ? i_cfg.e0_sz : i_cfg.e1_sz;
	assign step = {{(`RDM_CNT_W-2){1'b0}}, i_cfg.two_layer, !i_cfg.two_layer};

	assign o_cb_end = !(re_cnt < limit);
	assign o_word_addr = re_cnt;    // Offset from the user base
	assign o_cb_size = re_cnt + step;    // Words used by the block

	always_ff @(posedge i_core_clk or negedge i_rx_rstn)
	begin
		if (!i_rx_rstn)
		begin
			re_cnt <= '0;
			cb_cnt <= '0;
			o_half <= 1'b0;
		end
		else if (i_slot_start)
		begin
			re_cnt <= '0;    // Half carries over into the next slot
			cb_cnt <= '0;
		end
		else if (i_accept)
		begin
			if (o_cb_end)
			begin
				re_cnt <= '0;
				cb_cnt <= cb_cnt + 1'b1;
				o_half <= !o_half;
			end
			else
				re_cnt <= re_cnt + step;
		end
	end

	// Two-layer steps may pass an odd limit by one
	assert property (@(posedge i_core_clk) disable iff (!i_rx_rstn)
		re_cnt <= limit + step);

endmodule

// File: include/rdm_settings.svh
/*
 * Build constants of the input stage: user and bank counts,
 * field widths and the setup length
 */
`ifndef RDM_SETTINGS_SVH
`define RDM_SETTINGS_SVH

// Users and banks
`define RDM_NUM_USERS     8
`define RDM_NUM_BANKS     16
`define RDM_BANK_W        48
`define RDM_BUF_AW        11    // MSB selects the ping-pong half

// Per-user counters and configuration fields
`define RDM_CNT_W         14
`define RDM_SZ_W          16
`define RDM_CB_W          8
`define RDM_QM_W          4

// Demux sample
`define RDM_LLR_W         6
`define RDM_DEMUX_W       96

`define RDM_SETUP_CYCLES  9     // One cycle per user plus one

`endif

// File: sources.f
+incdir+include
hdl/rdm_pkg.sv
hdl/rdm_buf_wr_if.sv
hdl/rdm_slot_setup.sv
hdl/rdm_user_ctx.sv
hdl/rdm_addr_ctrl.sv
hdl/rdm_llr_packer.sv
hdl/rdm_input_buffer.sv
hdl/rdm_input_stage.sv
testbench/tb_rdm_input_stage.sv

// File: testbench/rdm_testdata.txt
// Entries: C user e0_sz e1_sz e0_num two_layer qm | 5 slot start | D user sample
//          B user half size (expected record) | F end. Hex, sizes are limits (REs minus one)
C 0 0003 0001 01 0 2
C 1 0002 0024 02 1 4
C 2 0000 0000 00 1 1
C 3 0002 0002 00 1 6
C 4 0002 0002 00 1 8
C 5 0020 0020 00 0 2
C 6 0002 0002 00 1 3
C 7 001f 001f 00 0 2
5
// Slot one, all users in half 0
D 0 5a5a5a5a5a5a0000a1a1a1a1
D 0 5a5a5a5a5a5a0000a2a2a2a2
D 0 5a5a5a5a5a5a0000a3a3a3a3
D 0 5a5a5a5a5a5a0000a4a4a4a4
B 0 0 0004
D 1 fedcba9876543210fedcba98
D 1 0123456789abcdef01234567
B 1 0 0004
D 2 ffffffffffffffffffffffff
B 2 0 0002
D 3 89abcdef0123456789abcdef
D 4 c3c3c3c3c3c33c3c3c3c3c3c
D 6 ffffffffffffffffffffffff
// User 0 now on E1 size in half 1
D 0 0000000000007777b1b1b1b1
D 0 0000000000007777b2b2b2b2
B 0 1 0002
5
// Slot two keeps each user's half
D 1 aaaaaaaaaaaa555555555555
D 1 13579bdf02468ace13579bdf
B 1 1 0004
D 2 00000000000000000000003f
B 2 1 0002
D 0 ffffffffffff00000000c0de
D 7 0000000000001234567890ab
D 5 000000000000fedcba987654
F

// File: testbench/tb_rdm_input_stage.sv
/*
 * Testbench of the input stage: slot setups, RE stream and code-block
 * records read from a data file, checked against a local address and packing model
 */
`timescale 1ns/1ps
`include "rdm_settings.svh"

module tb_rdm_input_stage;

	localparam int          TD_DEPTH = 512;
	localparam int          HALF_ROW = 1 << (`RDM_BUF_AW - 1);
	localparam logic [95:0] TAG_CFG  = 96'hC;
	localparam logic [95:0] TAG_SLOT = 96'h5;
	localparam logic [95:0] TAG_RE   = 96'hD;
	localparam logic [95:0] TAG_REC  = 96'hB;
	localparam logic [95:0] TAG_END  = 96'hF;

	logic                                  i_core_clk;
	logic                                  i_rx_rstn;
	logic                                  i_rdm_slot_start;
	logic [`RDM_NUM_USERS*`RDM_SZ_W-1:0]   i_users_e0_sz;
	logic [`RDM_NUM_USERS*`RDM_SZ_W-1:0]   i_users_e1_sz;
	logic [`RDM_NUM_USERS*`RDM_CB_W-1:0]   i_users_e0_num;
	logic [`RDM_NUM_USERS-1:0]             i_layer_indicator;
	logic [`RDM_NUM_USERS*`RDM_QM_W-1:0]   i_users_qm;
	logic                                  i_demux_valid;
	logic [3:0]                            i_demux_user_idx;
	logic [`RDM_DEMUX_W-1:0]               i_demux_rx;
	logic                                  i_cb_ready;
	logic [`RDM_BUF_AW-1:0]                i_rd_addr;
	logic                                  o_demux_ready;
	logic                                  o_cb_valid;
	logic [3:0]                            o_cb_user;
	logic                                  o_cb_half;
	logic [`RDM_CNT_W-1:0]                 o_cb_size;
	logic [`RDM_NUM_BANKS*`RDM_BANK_W-1:0] o_rd_data;

	logic [95:0] td [0:TD_DEPTH-1];
	logic [`RDM_BANK_W-1:0] shadow [0:`RDM_NUM_BANKS-1][0:(1 << `RDM_BUF_AW)-1];    // Expected buffer
	int     cfg_e0_sz [0:`RDM_NUM_USERS-1];
	int     cfg_e1_sz [0:`RDM_NUM_USERS-1];
	int     cfg_e0_num [0:`RDM_NUM_USERS-1];
	int     cfg_two [0:`RDM_NUM_USERS-1];
	int     cfg_qm [0:`RDM_NUM_USERS-1];
	int     base_addr [0:`RDM_NUM_USERS-1];
	int     re_cnt [0:`RDM_NUM_USERS-1];
	int     cb_cnt [0:`RDM_NUM_USERS-1];
	bit     half [0:`RDM_NUM_USERS-1];
	bit     rec_due;
	int     exp_user;
	int     exp_half;
	int     exp_size;
	integer seed;
	int     wd_cycles;

	rdm_input_stage dut0
	(
		.i_core_clk        (i_core_clk),
		.i_rx_rstn         (i_rx_rstn),
		.i_rdm_slot_start  (i_rdm_slot_start),
		.i_users_e0_sz     (i_users_e0_sz),
		.i_users_e1_sz     (i_users_e1_sz),
		.i_users_e0_num    (i_users_e0_num),
		.i_layer_indicator (i_layer_indicator),
		.i_users_qm        (i_users_qm),
		.i_demux_valid     (i_demux_valid),
		.i_demux_user_idx  (i_demux_user_idx),
		.i_demux_rx        (i_demux_rx),
		.i_cb_ready        (i_cb_ready),
		.i_rd_addr         (i_rd_addr),
		.o_demux_ready     (o_demux_ready),
		.o_cb_valid        (o_cb_valid),
		.o_cb_user         (o_cb_user),
		.o_cb_half         (o_cb_half),
		.o_cb_size         (o_cb_size),
		.o_rd_data         (o_rd_data)
	);

	initial
		i_core_clk = 1'b0;
	always #50 i_core_clk = !i_core_clk;

	//////////////////////////////////////////////////
	// Helpers

	task automatic stop_run();
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] want);
		if (got !== want)
		begin
			$display("Fail %s: got %h, expected %h", name, got, want);
			stop_run();
		end
	endtask

	task automatic next_cycle();
		@(posedge i_core_clk);
		#5;    // Inputs change just after the edge
	endtask

	function automatic int arg_count(input logic [95:0] tag);
		case (tag)
			TAG_CFG: return 6;
			TAG_RE:  return 2;
			TAG_REC: return 3;
			default: return 0;
		endcase
	endfunction

	task automatic start_slot();
		int u;
		int acc;
		acc = 0;
		for (u = 0; u < `RDM_NUM_USERS; u++)
		begin
			base_addr[u] = acc;    // Sum of rounded E1 sizes below this user
			acc = (acc + (cfg_e1_sz[u] / 16 + 1) * 16) % (1 << `RDM_CNT_W);
			re_cnt[u] = 0;
			cb_cnt[u] = 0;
		end
		next_cycle();
		i_rdm_slot_start = 1'b1;
		next_cycle();
		i_rdm_slot_start = 1'b0;
		repeat (`RDM_SETUP_CYCLES)
		begin
			check_eq("o_demux_ready", o_demux_ready, 0);
			next_cycle();
		end
		check_eq("o_demux_ready", o_demux_ready, 1);
	endtask

	task automatic send_re(input int u, input logic [95:0] smp);
		int          word;
		int          row;
		int          bank;
		int          pair;
		int          limit;
		int          step;
		int          w;
		int          b;
		bit          ends;
		logic [95:0] mask;
		logic [95:0] tmp;
		i_demux_valid = 1'b1;
		i_demux_user_idx = u[3:0];
		i_demux_rx = smp;
		while (!o_demux_ready)
			next_cycle();
		next_cycle();    // Accepted and written at this edge
		i_demux_valid = 1'b0;

		word = (base_addr[u] + re_cnt[u]) % (1 << `RDM_CNT_W);
		row = half[u] * HALF_ROW + word / 16;
		bank = word % 16;
		if (cfg_two[u] == 0)
			shadow[bank][row] = smp[`RDM_BANK_W-1:0];
		else
		begin
			case (cfg_qm[u])
				1, 2, 4, 6, 8: w = `RDM_LLR_W * cfg_qm[u];
				default: w = 0;
			endcase
			mask = (96'd1 << w) - 96'd1;
			pair = bank - bank % 2;
			tmp = smp & mask;
			shadow[pair][row] = tmp[`RDM_BANK_W-1:0];
			tmp = (smp >> w) & mask;
			shadow[pair + 1][row] = tmp[`RDM_BANK_W-1:0];
		end

		// Code-block end and counter update
		limit = (cb_cnt[u] < cfg_e0_num[u]) ? cfg_e0_sz[u] : cfg_e1_sz[u];
		step = (cfg_two[u] != 0) ? 2 : 1;
		ends = (re_cnt[u] >= limit);
		if (ends)
		begin
			rec_due = 1'b1;
			exp_user = u;
			exp_half = half[u];
			exp_size = re_cnt[u] + step;
			re_cnt[u] = 0;
			cb_cnt[u]++;
			half[u] = !half[u];
		end
		else
			re_cnt[u] += step;
		check_eq("o_cb_valid", o_cb_valid, ends);

		i_rd_addr = row[`RDM_BUF_AW-1:0];
		next_cycle();
		for (b = 0; b < `RDM_NUM_BANKS; b++)
			check_eq($sformatf("o_rd_data[%0d]", b), o_rd_data[b*`RDM_BANK_W +: `RDM_BANK_W],
				shadow[b][row]);
	endtask

	task automatic take_record(input int u, input int h, input int sz);
		int gap;
		if (!rec_due)
		begin
			$display("Test data lists a code-block record where the model ends no block");
			stop_run();
		end
		check_eq("o_cb_valid", o_cb_valid, 1);
		check_eq("o_demux_ready", o_demux_ready, 0);
		check_eq("o_cb_user", o_cb_user, exp_user);
		check_eq("o_cb_half", o_cb_half, exp_half);
		check_eq("o_cb_size", o_cb_size, exp_size);
		check_eq("o_cb_user", o_cb_user, u);
		check_eq("o_cb_half", o_cb_half, h);
		check_eq("o_cb_size", o_cb_size, sz);
		gap = $unsigned($random(seed)) % 4;
		repeat (gap)
		begin
			next_cycle();
			check_eq("o_demux_ready", o_demux_ready, 0);    // Record still held
			check_eq("o_cb_valid", o_cb_valid, 1);
			check_eq("o_cb_user", o_cb_user, u);
			check_eq("o_cb_half", o_cb_half, h);
			check_eq("o_cb_size", o_cb_size, sz);
		end
		i_cb_ready = 1'b1;
		next_cycle();
		i_cb_ready = 1'b0;
		rec_due = 1'b0;
		check_eq("o_cb_valid", o_cb_valid, 0);
	endtask

	//////////////////////////////////////////////////
	// Watchdog

	initial
	begin
		wait (wd_cycles > 0);
		repeat (wd_cycles) @(posedge i_core_clk);
		$display("Timeout: run did not finish within %0d cycles", wd_cycles);
		stop_run();
	end

	initial
	begin
		int idx;
		int u;
		int n_re;
		int n_rec;
		int n_slot;
		i_rx_rstn = 1'b0;
		i_rdm_slot_start = 1'b0;
		i_users_e0_sz = '0;
		i_users_e1_sz = '0;
		i_users_e0_num = '0;
		i_layer_indicator = '0;
		i_users_qm = '0;
		i_demux_valid = 1'b0;
		i_demux_user_idx = '0;
		i_demux_rx = '0;
		i_cb_ready = 1'b0;
		i_rd_addr = '0;
		seed = 32'h3587_1f41;
		rec_due = 1'b0;
		$readmemh("testbench/rdm_testdata.txt", td);

		idx = 0;
		n_re = 0;
		n_rec = 0;
		n_slot = 0;
		while (idx < TD_DEPTH && td[idx] !== TAG_END)
		begin
			n_re += (td[idx] === TAG_RE);
			n_rec += (td[idx] === TAG_REC);
			n_slot += (td[idx] === TAG_SLOT);
			idx += 1 + arg_count(td[idx]);
		end
		wd_cycles = 8 + n_re * 3 + n_rec * 6 + n_slot * (`RDM_SETUP_CYCLES + 2) + 200;

		repeat (8) @(posedge i_core_clk);
		#5;
		i_rx_rstn = 1'b1;

		idx = 0;
		while (idx < TD_DEPTH && td[idx] !== TAG_END)
		begin
			case (td[idx])
				TAG_CFG:
				begin
					u = int'(td[idx + 1][3:0]);
					cfg_e0_sz[u] = int'(td[idx + 2][`RDM_SZ_W-1:0]);
					cfg_e1_sz[u] = int'(td[idx + 3][`RDM_SZ_W-1:0]);
					cfg_e0_num[u] = int'(td[idx + 4][`RDM_CB_W-1:0]);
					cfg_two[u] = int'(td[idx + 5][0]);
					cfg_qm[u] = int'(td[idx + 6][`RDM_QM_W-1:0]);
					i_users_e0_sz[u*`RDM_SZ_W +: `RDM_SZ_W] = td[idx + 2][`RDM_SZ_W-1:0];
					i_users_e1_sz[u*`RDM_SZ_W +: `RDM_SZ_W] = td[idx + 3][`RDM_SZ_W-1:0];
					i_users_e0_num[u*`RDM_CB_W +: `RDM_CB_W] = td[idx + 4][`RDM_CB_W-1:0];
					i_layer_indicator[u] = td[idx + 5][0];
					i_users_qm[u*`RDM_QM_W +: `RDM_QM_W] = td[idx + 6][`RDM_QM_W-1:0];
				end
				TAG_SLOT: start_slot();
				TAG_RE: send_re(int'(td[idx + 1][3:0]), td[idx + 2]);
				TAG_REC: take_record(int'(td[idx + 1][3:0]), int'(td[idx + 2][0]),
					int'(td[idx + 3][`RDM_CNT_W-1:0]));
				default:
				begin
					$display("Unknown entry %h at word %0d of the test data", td[idx], idx);
					stop_run();
				end
			endcase
			idx += 1 + arg_count(td[idx]);
		end

		next_cycle();
		$display("All tests passed!");
		$finish;
	end

endmodule
